/* verilog/ilk_defs.svh */
// lane count, word count width, word widths and counter width macros
`ifndef ILK_DEFS_SVH
`define ILK_DEFS_SVH

// lanes per beat
`define ILK_WORDS 4

// width of a valid word count, must hold ILK_WORDS
`define ILK_LOG_WORDS 3

// payload bits per lane word
`define ILK_DATA_W 64

// payload plus the control flag in bit 64
`define ILK_WORD_W 65

// width of the packet and error counters in the monitor
`define ILK_CNT_W 16

`endif

/* verilog/ilk_word_pkg.sv */
// lane word, beat, word count, lane mask, eop field and annotated beat types
`default_nettype none

`include "ilk_defs.svh"

package ilk_word_pkg;

	// one lane word, ctrl lands in bit 64
	typedef struct packed {
		logic                   ctrl;
		logic [`ILK_DATA_W-1:0] data;
	} lane_word_t;

	// lane ILK_WORDS-1 holds the oldest word of the beat
	typedef lane_word_t [`ILK_WORDS-1:0] beat_t;

	// number of valid words in a beat
	typedef logic [`ILK_LOG_WORDS-1:0] word_cnt_t;

	// one bit per lane
	typedef logic [`ILK_WORDS-1:0] lane_mask_t;

	// bit 3 marks eop, bits 2..0 count valid bytes with 0 meaning 8
	typedef logic [3:0] eop_bits_t;

	// payload of all lanes with control flags stripped
	typedef logic [`ILK_WORDS-1:0][`ILK_DATA_W-1:0] beat_data_t;

	// eop field per lane
	typedef eop_bits_t [`ILK_WORDS-1:0] eop_vec_t;

	// annotated beat leaving the annotator
	typedef struct packed {
		beat_data_t data;
		lane_mask_t valid;
		lane_mask_t sop;
		eop_vec_t   eop;
	} ann_beat_t;

	typedef logic [`ILK_CNT_W-1:0] pkt_cnt_t;

endpackage

`default_nettype wire

/* verilog/ilk_ctrl_pkg.sv */
// control word bit positions and the framing state enum
`default_nettype none

`include "ilk_defs.svh"

package ilk_ctrl_pkg;

	// index into the 64 payload bits of a control word
	typedef logic [$clog2(`ILK_DATA_W)-1:0] ctrl_pos_t;

	// set for burst and idle control words
	localparam ctrl_pos_t CTRL_TYPE_POS = 6'd63;

	// burst start, channel and sop info are meaningful only with this set
	localparam ctrl_pos_t CTRL_BURST_POS = 6'd62;

	localparam ctrl_pos_t CTRL_SOP_POS = 6'd61;

	// eop field of the word before this one
	localparam ctrl_pos_t CTRL_EOP_MSB = 6'd60;
	localparam ctrl_pos_t CTRL_EOP_LSB = 6'd57;

	// receive framing state
	typedef enum logic {
		FRAME_IDLE,
		FRAME_IN_PKT
	} frame_state_e;

endpackage

`default_nettype wire

/* verilog/ilk_rx_word_compact.sv */
// lane word compactor, packs valid words toward the top lane and counts them
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_rx_word_compact (
	input  wire                            clk,
	input  wire                            arst,
	input  wire ilk_word_pkg::beat_t       lanes_i,
	input  wire ilk_word_pkg::lane_mask_t  lane_valid_i,
	output ilk_word_pkg::beat_t            beat_o,
	output ilk_word_pkg::word_cnt_t        cnt_o
);

	//////////////////////////////////////////////////
	// pack valid words
	//////////////////////////////////////////////////

	ilk_word_pkg::beat_t     packed_beat;
	ilk_word_pkg::word_cnt_t fill;

	// walk lanes oldest first, each valid word takes the next free lane
	// counting down from the top, so order in time is kept
	always_comb begin
		packed_beat = '0;
		fill = '0;
		for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
			if (lane_valid_i[i]) begin
				packed_beat[`ILK_WORDS - 1 - int'(fill)] = lanes_i[i];
				fill = fill + ilk_word_pkg::word_cnt_t'(1);
			end
		end
	end

	// lanes below the count stay zero from the default above

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	// one cycle from lanes_i to beat_o
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			beat_o <= '0;
			cnt_o <= '0;
		end
		else begin
			beat_o <= packed_beat;
			// count of zero tells the annotator the beat is empty
			cnt_o <= fill;
		end
	end

endmodule

`default_nettype wire

/* verilog/ilk_rx_packet_annotate.sv */
// packet annotator, strips control words and moves sop and eop onto data words
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_rx_packet_annotate (
	input  wire                           clk,
	input  wire                           arst,
	input  wire ilk_word_pkg::beat_t      beat_i,
	input  wire ilk_word_pkg::word_cnt_t  cnt_i,
	output ilk_word_pkg::ann_beat_t       ann_o
);

	//////////////////////////////////////////////////
	// input register
	//////////////////////////////////////////////////

	ilk_word_pkg::beat_t     in_beat_q;
	ilk_word_pkg::word_cnt_t in_cnt_q;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			in_beat_q <= '0;
			in_cnt_q <= '0;
		end
		else begin
			in_beat_q <= beat_i;
			in_cnt_q <= cnt_i;
		end
	end

	//////////////////////////////////////////////////
	// word decode
	//////////////////////////////////////////////////

	ilk_word_pkg::lane_mask_t in_range;
	ilk_word_pkg::lane_mask_t in_eop_info;
	ilk_word_pkg::lane_mask_t in_sop;
	ilk_word_pkg::lane_mask_t in_payload;
	ilk_word_pkg::lane_mask_t in_last_data;
	ilk_word_pkg::eop_vec_t   in_eop;
	ilk_word_pkg::eop_bits_t  next_eop;

	always_comb begin
		for (int i = 0; i < `ILK_WORDS; i++) begin
			// lane holds a real word when it sits inside the count
			in_range[i] = in_cnt_q >= ilk_word_pkg::word_cnt_t'(`ILK_WORDS - i);
			// burst and idle words both carry eop for the word before them
			in_eop_info[i] = in_range[i] & in_beat_q[i].ctrl &
				in_beat_q[i].data[ilk_ctrl_pkg::CTRL_TYPE_POS];
			// only a burst word carries sop
			in_sop[i] = in_eop_info[i] &
				in_beat_q[i].data[ilk_ctrl_pkg::CTRL_BURST_POS] &
				in_beat_q[i].data[ilk_ctrl_pkg::CTRL_SOP_POS];
			in_eop[i] = in_eop_info[i] ?
				in_beat_q[i].data[ilk_ctrl_pkg::CTRL_EOP_MSB:ilk_ctrl_pkg::CTRL_EOP_LSB] :
				4'h0;
			in_payload[i] = in_range[i] & ~in_beat_q[i].ctrl;
			// rightmost valid word is lane ILK_WORDS-cnt
			in_last_data[i] = ~in_beat_q[i].ctrl &
				(in_cnt_q == ilk_word_pkg::word_cnt_t'(`ILK_WORDS - i));
		end
	end

	// leading word of the next beat closes a held beat
	assign next_eop = in_eop[`ILK_WORDS-1];

	//////////////////////////////////////////////////
	// mid register
	//////////////////////////////////////////////////

	ilk_word_pkg::beat_data_t mid_data;
	ilk_word_pkg::word_cnt_t  mid_cnt;
	ilk_word_pkg::lane_mask_t mid_sop;
	ilk_word_pkg::eop_vec_t   mid_eop;
	ilk_word_pkg::lane_mask_t mid_payload;
	ilk_word_pkg::lane_mask_t last_word_mask;
	logic                     mid_valid;
	logic                     mid_last_data;
	logic                     last_sop;
	logic                     update;

	// payload only, qualified by mid_payload
	always_ff @(posedge clk) begin
		if (|in_cnt_q) begin
			for (int i = 0; i < `ILK_WORDS; i++) begin
				mid_data[i] <= in_beat_q[i].data;
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			mid_cnt <= '0;
			mid_sop <= '0;
			mid_eop <= '0;
			mid_payload <= '0;
			mid_valid <= 1'b0;
			mid_last_data <= 1'b0;
			last_sop <= 1'b0;
		end
		else begin
			if (update) begin
				mid_valid <= 1'b0;
			end
			// empty beats pass by without disturbing the held one
			if (|in_cnt_q) begin
				mid_cnt <= in_cnt_q;
				mid_sop <= in_sop;
				mid_eop <= in_eop;
				mid_payload <= in_payload;
				mid_valid <= 1'b1;
				mid_last_data <= |in_last_data;
				// sop of the outgoing rightmost word carries to the next beat
				last_sop <= |(mid_sop & last_word_mask);
			end
		end
	end

	//////////////////////////////////////////////////
	// annotate
	//////////////////////////////////////////////////

	ilk_word_pkg::lane_mask_t rightmost_payload;
	ilk_word_pkg::lane_mask_t out_valid;
	ilk_word_pkg::lane_mask_t out_sop;
	ilk_word_pkg::eop_vec_t   out_eop;

	// release once the eop of the last data word is known
	assign update = mid_valid & (~mid_last_data | (|in_cnt_q));

	// isolate the lowest set payload bit, i.e. the last data word in time
	assign rightmost_payload = mid_payload & ilk_word_pkg::lane_mask_t'(~mid_payload + 1'b1);

	assign out_valid = mid_payload & {`ILK_WORDS{update}};

	// sop moves one word later in time, one lane down
	assign out_sop = {last_sop, mid_sop[`ILK_WORDS-1:1]} & out_valid;

	always_comb begin
		for (int i = 0; i < `ILK_WORDS; i++) begin
			last_word_mask[i] = mid_cnt == ilk_word_pkg::word_cnt_t'(`ILK_WORDS - i);
			out_eop[i] = 4'h0;
			// eop moves one word earlier in time, one lane up
			if (i > 0) begin
				out_eop[i] = mid_eop[i-1];
			end
			// held beat ending in data takes eop from the next beat
			if (rightmost_payload[i] && mid_last_data) begin
				out_eop[i] = out_eop[i] | next_eop;
			end
			if (!out_valid[i]) begin
				out_eop[i] = 4'h0;
			end
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			ann_o <= '0;
		end
		else begin
			ann_o.data <= mid_data;
			ann_o.valid <= out_valid;
			ann_o.sop <= out_sop;
			ann_o.eop <= out_eop;
		end
	end

endmodule

`default_nettype wire

/* verilog/ilk_rx_packet_monitor.sv */
// framing monitor, counts good packets and framing errors on annotated beats
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_rx_packet_monitor (
	input  wire                           clk,
	input  wire                           arst,
	input  wire ilk_word_pkg::ann_beat_t  ann_i,
	output logic                          in_pkt_o,
	output ilk_word_pkg::pkt_cnt_t        pkt_cnt_o,
	output ilk_word_pkg::pkt_cnt_t        err_cnt_o
);

	// counter add that sticks at all ones
	function automatic ilk_word_pkg::pkt_cnt_t sat_add(
		input ilk_word_pkg::pkt_cnt_t base,
		input ilk_word_pkg::pkt_cnt_t inc
	);
		logic [`ILK_CNT_W:0] sum;
		sum = {1'b0, base} + {1'b0, inc};
		return sum[`ILK_CNT_W] ? '1 : sum[`ILK_CNT_W-1:0];
	endfunction

	//////////////////////////////////////////////////
	// lane walk
	//////////////////////////////////////////////////

	ilk_ctrl_pkg::frame_state_e state_q;
	ilk_ctrl_pkg::frame_state_e state_d;
	logic                       drop_q;
	logic                       drop_d;
	ilk_word_pkg::pkt_cnt_t     pkt_add;
	ilk_word_pkg::pkt_cnt_t     err_add;

	// drop_q marks a run of data seen without sop, one error per run
	always_comb begin
		state_d = state_q;
		drop_d = drop_q;
		pkt_add = '0;
		err_add = '0;
		for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
			if (ann_i.valid[i]) begin
				if (ann_i.sop[i]) begin
					// sop while a packet is still open
					if (state_d == ilk_ctrl_pkg::FRAME_IN_PKT) begin
						err_add = err_add + 1'b1;
					end
					state_d = ilk_ctrl_pkg::FRAME_IN_PKT;
					drop_d = 1'b0;
				end
				else if (state_d == ilk_ctrl_pkg::FRAME_IDLE && !drop_d) begin
					err_add = err_add + 1'b1;
					drop_d = 1'b1;
				end
				if (ann_i.eop[i][3]) begin
					if (state_d == ilk_ctrl_pkg::FRAME_IN_PKT) begin
						pkt_add = pkt_add + 1'b1;
					end
					state_d = ilk_ctrl_pkg::FRAME_IDLE;
					drop_d = 1'b0;
				end
				else if (ann_i.eop[i][2:0] != 3'd0) begin
					// byte count without the eop flag, an aborted packet
					err_add = err_add + 1'b1;
					state_d = ilk_ctrl_pkg::FRAME_IDLE;
					drop_d = 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// state and counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			state_q <= ilk_ctrl_pkg::FRAME_IDLE;
			drop_q <= 1'b0;
			pkt_cnt_o <= '0;
			err_cnt_o <= '0;
		end
		else begin
			state_q <= state_d;
			drop_q <= drop_d;
			pkt_cnt_o <= sat_add(pkt_cnt_o, pkt_add);
			err_cnt_o <= sat_add(err_cnt_o, err_add);
		end
	end

	assign in_pkt_o = (state_q == ilk_ctrl_pkg::FRAME_IN_PKT);

endmodule

`default_nettype wire

/* verilog/ilk_rx_annotate_top.sv */
// receive annotation top level with compactor, annotator and framing monitor
`timescale 1ns/1ps
`default_nettype none

module ilk_rx_annotate_top (
	input  wire                            clk,
	input  wire                            arst,
	input  wire ilk_word_pkg::beat_t       lanes_i,
	input  wire ilk_word_pkg::lane_mask_t  lane_valid_i,
	output ilk_word_pkg::ann_beat_t        ann_o,
	output logic                           in_pkt_o,
	output ilk_word_pkg::pkt_cnt_t         pkt_cnt_o,
	output ilk_word_pkg::pkt_cnt_t         err_cnt_o
);

	// compacted beat and its word count
	ilk_word_pkg::beat_t     cbeat;
	ilk_word_pkg::word_cnt_t cnt;

	ilk_rx_word_compact u_compact (
		.clk          (clk),
		.arst         (arst),
		.lanes_i      (lanes_i),
		.lane_valid_i (lane_valid_i),
		.beat_o       (cbeat),
		.cnt_o        (cnt)
	);

	// at least three cycles, longer while a beat waits for its eop
	ilk_rx_packet_annotate u_annotate (
		.clk    (clk),
		.arst   (arst),
		.beat_i (cbeat),
		.cnt_i  (cnt),
		.ann_o  (ann_o)
	);

	// counters follow ann_o by one cycle
	ilk_rx_packet_monitor u_monitor (
		.clk       (clk),
		.arst      (arst),
		.ann_i     (ann_o),
		.in_pkt_o  (in_pkt_o),
		.pkt_cnt_o (pkt_cnt_o),
		.err_cnt_o (err_cnt_o)
	);

endmodule

`default_nettype wire

/* tb/ilk_rx_annotate_properties.sv */
// concurrent assertions on the annotator input and output, bound into the annotator
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_rx_annotate_properties (
	input wire                           clk,
	input wire                           arst,
	input wire ilk_word_pkg::ann_beat_t  ann_i,
	input wire ilk_word_pkg::beat_t      beat_i,
	input wire ilk_word_pkg::word_cnt_t  cnt_i
);

	logic                     eop_stray;
	ilk_word_pkg::lane_mask_t counted;
	ilk_word_pkg::lane_mask_t spill;

	// counted marks the block of lanes filled from the top by the incoming beat
	always_comb begin
		eop_stray = 1'b0;
		for (int i = 0; i < `ILK_WORDS; i++) begin
			if (!ann_i.valid[i] && ann_i.eop[i] != 4'h0) begin
				eop_stray = 1'b1;
			end
			counted[i] = cnt_i >= ilk_word_pkg::word_cnt_t'(`ILK_WORDS - i);
			spill[i] = !counted[i] && beat_i[i] != '0;
		end
	end

	a_quiet_lanes: assert property (@(posedge clk) disable iff (arst)
		((ann_i.sop & ~ann_i.valid) == '0) && !eop_stray)
		else $error("sop or eop set on a lane that is not valid");

	a_idle_after_reset: assert property (@(posedge clk)
		$fell(arst) |-> (ann_i.valid == '0 && ann_i.sop == '0 && ann_i.eop == '0))
		else $error("annotated output not idle right after reset");

	// valid lanes of ann can only come from words packed at the top lanes
	a_top_aligned: assert property (@(posedge clk) disable iff (arst)
		spill == '0)
		else $error("word below the packed block of the beat entering the annotator");

endmodule

`default_nettype wire

/* tb/ilk_rx_annotate_tb.sv */
// testbench with stimulus table, random packets, reference model and scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "ilk_defs.svh"

module ilk_rx_annotate_tb;

	// word kinds used in the stimulus table
	localparam logic [1:0] K_DAT = 2'd0;
	localparam logic [1:0] K_BRST = 2'd1;
	localparam logic [1:0] K_SOP = 2'd2;
	localparam logic [1:0] K_IDLE = 2'd3;
	localparam int N_ROWS = 16;
	localparam int N_PKTS = 24;
	// first non-empty row after the held beat of row 0
	localparam int HELD_ROW = 5;

	// lane 3 first, pkts and errs are what the row closes or injects
	typedef struct packed {
		ilk_word_pkg::lane_mask_t        valid;
		logic [`ILK_WORDS-1:0][1:0]      kind;
		ilk_word_pkg::eop_vec_t          eop;
		logic [3:0]                      pkts;
		logic [3:0]                      errs;
	} row_t;

	// one expected annotated data word
	typedef struct packed {
		logic [`ILK_DATA_W-1:0]   data;
		logic                     sop;
		ilk_word_pkg::eop_bits_t  eop;
	} exp_word_t;

	logic                      clk;
	logic                      arst;
	ilk_word_pkg::beat_t       lanes_i;
	ilk_word_pkg::lane_mask_t  lane_valid_i;
	ilk_word_pkg::ann_beat_t   ann_o;
	logic                      in_pkt_o;
	ilk_word_pkg::pkt_cnt_t    pkt_cnt_o;
	ilk_word_pkg::pkt_cnt_t    err_cnt_o;

	row_t                      rows [N_ROWS];
	ilk_word_pkg::beat_t       beat_q[$];
	ilk_word_pkg::lane_mask_t  mask_q[$];
	exp_word_t                 exp_q[$];
	exp_word_t                 exp_w;
	logic                      exp_in_pkt = 1'b0;
	logic [63:0]               rng = 64'd73927;
	int                        errors = 0;
	int                        seen = 0;
	int                        exp_pkts = 0;
	int                        exp_errs = 0;
	int                        tab_pkts = 0;
	int                        tab_errs = 0;

	ilk_rx_annotate_top uut (
		.clk          (clk),
		.arst         (arst),
		.lanes_i      (lanes_i),
		.lane_valid_i (lane_valid_i),
		.ann_o        (ann_o),
		.in_pkt_o     (in_pkt_o),
		.pkt_cnt_o    (pkt_cnt_o),
		.err_cnt_o    (err_cnt_o)
	);

	bind ilk_rx_packet_annotate ilk_rx_annotate_properties u_props (
		.clk    (clk),
		.arst   (arst),
		.ann_i  (ann_o),
		.beat_i (beat_i),
		.cnt_i  (cnt_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	function logic [63:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 7);
		rng = rng ^ (rng << 17);
		return rng;
	endfunction

	// control words get type bit, burst bit, sop bit and eop field, channel bits random
	function ilk_word_pkg::lane_word_t make_word(input logic [1:0] kind, input logic [3:0] eop);
		logic [63:0] r;
		r = next_rand();
		if (kind == K_DAT) begin
			return {1'b0, r};
		end
		return {1'b1, 1'b1, kind != K_IDLE, kind == K_SOP, eop, r[56:0]};
	endfunction

	// lanes without valid carry noise, ctrl flag included
	function ilk_word_pkg::lane_word_t junk_word();
		logic [63:0] r;
		r = next_rand();
		return {r[7], r};
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic load_table();
		ilk_word_pkg::beat_t b;
		for (int n = 0; n < N_ROWS; n++) begin
			rows[n] = {4'b0000, 8'h00, 16'h0000, 4'd0, 4'd0};
		end
		// row 0 ends in data and waits through rows 1 to 4
		rows[0] = {4'b1111, {K_SOP, K_DAT, K_DAT, K_DAT}, 16'h0000, 4'd0, 4'd0};
		// eop from next beat, sop carried out of the last lane
		rows[5] = {4'b1101, {K_DAT, K_IDLE, K_DAT, K_SOP}, 16'h0A00, 4'd1, 4'd0};
		rows[6] = {4'b1011, {K_DAT, K_DAT, K_DAT, K_BRST}, 16'h000C, 4'd1, 4'd0};
		// packet without sop
		rows[7] = {4'b1111, {K_DAT, K_DAT, K_DAT, K_DAT}, 16'h0000, 4'd0, 4'd1};
		rows[8] = {4'b1000, {K_IDLE, K_DAT, K_DAT, K_DAT}, 16'h8000, 4'd0, 4'd0};
		// doubled sop
		rows[9] = {4'b1110, {K_SOP, K_DAT, K_SOP, K_DAT}, 16'h0000, 4'd0, 4'd1};
		rows[10] = {4'b1100, {K_DAT, K_IDLE, K_DAT, K_DAT}, 16'h0900, 4'd1, 4'd0};
		// byte count without the eop flag
		rows[11] = {4'b0111, {K_DAT, K_SOP, K_DAT, K_IDLE}, 16'h0003, 4'd0, 4'd1};
		rows[12] = {4'b1111, {K_SOP, K_DAT, K_IDLE, K_SOP}, 16'h00F0, 4'd1, 4'd0};
		rows[13] = {4'b0001, {K_DAT, K_DAT, K_DAT, K_DAT}, 16'h0000, 4'd0, 4'd0};
		rows[15] = {4'b0100, {K_DAT, K_IDLE, K_DAT, K_DAT}, 16'h0800, 4'd1, 4'd0};
		for (int n = 0; n < N_ROWS; n++) begin
			for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
				if (rows[n].valid[i]) begin
					b[i] = make_word(rows[n].kind[i], rows[n].eop[i]);
				end
				else begin
					b[i] = junk_word();
				end
			end
			beat_q.push_back(b);
			mask_q.push_back(rows[n].valid);
			tab_pkts += int'(rows[n].pkts);
			tab_errs += int'(rows[n].errs);
		end
	endtask

	// well framed packets spread over beats with random lane gaps
	task automatic add_random_packets();
		ilk_word_pkg::lane_word_t word_q[$];
		ilk_word_pkg::beat_t      b;
		ilk_word_pkg::lane_mask_t m;
		logic [63:0]              r;
		for (int p = 0; p < N_PKTS; p++) begin
			word_q.push_back(make_word(K_SOP, 4'h0));
			r = next_rand();
			for (int k = 0; k <= r % 6; k++) begin
				word_q.push_back(make_word(K_DAT, 4'h0));
			end
			r = next_rand();
			word_q.push_back(make_word(K_IDLE, {1'b1, r[2:0]}));
			tab_pkts++;
		end
		while (word_q.size() > 0) begin
			r = next_rand();
			m = r[3:0];
			for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
				if (m[i] && word_q.size() > 0) begin
					b[i] = word_q.pop_front();
				end
				else begin
					m[i] = 1'b0;
					b[i] = junk_word();
				end
			end
			beat_q.push_back(b);
			mask_q.push_back(m);
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	task automatic predict_output();
		ilk_word_pkg::lane_word_t stream[$];
		exp_word_t                e;
		logic                     in_pkt;
		logic                     stray;
		// flat word stream in time order
		for (int n = 0; n < beat_q.size(); n++) begin
			for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
				if (mask_q[n][i]) begin
					stream.push_back(beat_q[n][i]);
				end
			end
		end
		// sop from the word before, eop from the word after
		for (int p = 0; p < stream.size(); p++) begin
			if (!stream[p].ctrl) begin
				e.data = stream[p].data;
				e.sop = 1'b0;
				e.eop = 4'h0;
				if (p > 0 && stream[p-1].ctrl) begin
					e.sop = &stream[p-1].data[63:61];
				end
				if (p + 1 < stream.size() && stream[p+1].ctrl && stream[p+1].data[63]) begin
					e.eop = stream[p+1].data[60:57];
				end
				exp_q.push_back(e);
			end
		end
		// framing, one error per stray run of data
		in_pkt = 1'b0;
		stray = 1'b0;
		foreach (exp_q[k]) begin
			if (exp_q[k].sop) begin
				exp_errs += int'(in_pkt);
				in_pkt = 1'b1;
				stray = 1'b0;
			end
			else if (!in_pkt && !stray) begin
				exp_errs++;
				stray = 1'b1;
			end
			if (exp_q[k].eop[3]) begin
				exp_pkts += int'(in_pkt);
				in_pkt = 1'b0;
				stray = 1'b0;
			end
			else if (exp_q[k].eop != 4'h0) begin
				exp_errs++;
				in_pkt = 1'b0;
				stray = 1'b0;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	// outputs settle between edges, lanes read oldest first
	// in_pkt_o trails ann_o by one cycle so it is checked before this beat counts
	always @(negedge clk) begin
		if (!arst) begin
			compare_value("in_pkt_o", in_pkt_o, exp_in_pkt);
			for (int i = `ILK_WORDS - 1; i >= 0; i--) begin
				if (ann_o.valid[i]) begin
					seen++;
					if (exp_q.size() == 0) begin
						$display("unexpected annotated word on lane %0d", i);
						errors++;
					end
					else begin
						exp_w = exp_q.pop_front();
						compare_value("ann_o.data", ann_o.data[i], exp_w.data);
						compare_value("ann_o.sop", ann_o.sop[i], exp_w.sop);
						compare_value("ann_o.eop", ann_o.eop[i], exp_w.eop);
						// sop opens a packet and any eop code closes it
						if (exp_w.sop) begin
							exp_in_pkt = 1'b1;
						end
						if (exp_w.eop != 4'h0) begin
							exp_in_pkt = 1'b0;
						end
					end
				end
			end
		end
	end

	initial begin
		int cycles;
		arst = 1'b1;
		lanes_i = '0;
		lane_valid_i = '0;
		load_table();
		add_random_packets();
		predict_output();
		compare_value("model pkt count", exp_pkts, tab_pkts);
		compare_value("model err count", exp_errs, tab_errs);
		repeat (2) @(posedge clk);
		arst <= 1'b0;
		@(negedge clk);
		compare_value("ann_o.valid", ann_o.valid, 0);
		compare_value("ann_o.sop", ann_o.sop, 0);
		compare_value("ann_o.eop", ann_o.eop, 0);
		compare_value("pkt_cnt_o", pkt_cnt_o, 0);
		compare_value("err_cnt_o", err_cnt_o, 0);
		compare_value("in_pkt_o", in_pkt_o, 0);
		for (int n = 0; n < beat_q.size(); n++) begin
			@(posedge clk);
			// nothing may leave while row 0 waits for its eop
			if (n == HELD_ROW) begin
				compare_value("ann_o word count", seen, 0);
			end
			lanes_i <= beat_q[n];
			lane_valid_i <= mask_q[n];
		end
		@(posedge clk);
		lanes_i <= '0;
		lane_valid_i <= '0;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < 1000) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() > 0) begin
			$display("timed out with %0d annotated words still missing", exp_q.size());
			errors++;
		end
		// counters trail ann_o by one cycle
		@(negedge clk);
		compare_value("pkt_cnt_o", pkt_cnt_o, exp_pkts);
		compare_value("err_cnt_o", err_cnt_o, exp_errs);
		compare_value("in_pkt_o", in_pkt_o, 0);
		$display("errors: %0d, words checked: %0d", errors, seen);
		if (errors == 0) begin
			$display("TEST OK");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/ilk_word_pkg.sv
verilog/ilk_ctrl_pkg.sv
verilog/ilk_rx_word_compact.sv
verilog/ilk_rx_packet_annotate.sv
verilog/ilk_rx_packet_monitor.sv
verilog/ilk_rx_annotate_top.sv
tb/ilk_rx_annotate_properties.sv
tb/ilk_rx_annotate_tb.sv

/* Bender.yml */
package:
  name: ilk_rx_annotate

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/ilk_word_pkg.sv
      - verilog/ilk_ctrl_pkg.sv
      - verilog/ilk_rx_word_compact.sv
      - verilog/ilk_rx_packet_annotate.sv
      - verilog/ilk_rx_packet_monitor.sv
      - verilog/ilk_rx_annotate_top.sv
  - target: test
    files:
      - tb/ilk_rx_annotate_properties.sv
      - tb/ilk_rx_annotate_tb.sv
